//--- files.f
+incdir+hdl
+incdir+test
hdl/uncore_pkg.sv
hdl/two_fifo.sv
hdl/cmd_router.sv
hdl/resp_router.sv
hdl/cfg_regs.sv
hdl/loopback.sv
hdl/unicore_uncore.sv
test/tb_uncore.sv

//--- test/tb_uncore_tasks.svh
`ifndef TB_UNCORE_TASKS_SVH
`define TB_UNCORE_TASKS_SVH

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

function automatic mem_msg_s make_msg(mem_op_e op, logic [`PADDR_W-1:0] addr,
                                      logic [`SRC_ID_W-1:0] src, logic [`DATA_W-1:0] data);
  mem_msg_s msg;
  msg.op       = op;
  msg.addr.raw = addr;
  msg.src_id   = src;
  msg.data     = data;
  return msg;
endfunction

// Memory and I/O models echo the header with data taken from the address
function automatic mem_msg_s mem_reply(mem_msg_s cmd);
  mem_msg_s rsp;
  rsp      = cmd;
  rsp.data = {cmd.addr.raw[23:0], cmd.addr.raw} ^ 64'h5a5a_c3c3_0f0f_9696;
  return rsp;
endfunction

function automatic mem_msg_s io_reply(mem_msg_s cmd);
  mem_msg_s rsp;
  rsp      = cmd;
  rsp.data = {~cmd.addr.raw, cmd.addr.raw[39:16]};
  return rsp;
endfunction

function automatic logic [`PADDR_W-1:0] cfg_addr(int idx);
  return (`PADDR_W'(`CFG_DEV) << `DEV_LSB) | `PADDR_W'(idx * 8);
endfunction

task automatic report_mismatch(string name, logic [127:0] got, logic [127:0] exp);
  mismatches++;
  $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
endtask

task automatic report_failure(string what);
  failures++;
  $display("Error at %0t: %s", $time, what);
endtask

task automatic record_resp(mem_msg_s msg, int port);
  got_q.push_back(msg);
  got_port_q.push_back(port);
endtask

task automatic send_cmd(int port, mem_msg_s msg);
  int   cycles;
  logic done;
  cycles = 0;
  done   = 1'b0;
  @(negedge clk_i);
  if (port == 2)
  begin
    io_cmd_i   = msg;
    io_cmd_v_i = 1'b1;
  end
  else
  begin
    proc_cmd_i[port]   = msg;
    proc_cmd_v_i[port] = 1'b1;
  end
  while (!done && cycles < TIMEOUT)
  begin
    @(posedge clk_i);
    done = (port == 2) ? io_cmd_yumi_o : proc_cmd_ready_o[port];
    cycles++;
  end
  @(negedge clk_i);
  if (port == 2)
    io_cmd_v_i = 1'b0;
  else
    proc_cmd_v_i[port] = 1'b0;
  if (!done)
    report_failure($sformatf("command on port %0d was never accepted", port));
endtask

task automatic wait_resp(output mem_msg_s msg, output int port);
  int cycles;
  cycles = 0;
  msg    = '0;
  port   = -1;
  while (got_q.size() == 0 && cycles < TIMEOUT)
  begin
    @(negedge clk_i);
    cycles++;
  end
  if (got_q.size() == 0)
    report_failure("no response came back");
  else
  begin
    msg  = got_q.pop_front();
    port = got_port_q.pop_front();
  end
endtask

task automatic expect_resp(int port, mem_msg_s exp);
  mem_msg_s got;
  int       got_port;
  wait_resp(got, got_port);
  if (got_port >= 0 && got_port != port)
    report_mismatch("proc_resp port", got_port, port);
  if (got_port >= 0 && got !== exp)
    report_mismatch("proc_resp", got, exp);
endtask

task automatic expect_routed(bit to_io, mem_msg_s exp);
  int       cycles;
  mem_msg_s got;
  cycles = 0;
  while ((to_io ? io_seen_q.size() : mem_seen_q.size()) == 0 && cycles < TIMEOUT)
  begin
    @(negedge clk_i);
    cycles++;
  end
  if ((to_io ? io_seen_q.size() : mem_seen_q.size()) == 0)
    report_failure(to_io ? "no command reached io_cmd_o" : "no command reached mem_cmd_o");
  else
  begin
    got = to_io ? io_seen_q.pop_front() : mem_seen_q.pop_front();
    if (got !== exp)
      report_mismatch(to_io ? "io_cmd_o" : "mem_cmd_o", got, exp);
  end
endtask

// Write each cfg register from port 0 and read it back from port 1
task automatic cfg_test();
  logic [`DATA_W-1:0] data;
  for (int k = 0; k < `CFG_REGS; k++)
  begin
    data = {lcg_next(), lcg_next()};
    send_cmd(0, make_msg(e_mem_wr, cfg_addr(k), 0, data));
    expect_resp(0, make_msg(e_mem_wr, cfg_addr(k), 0, '0));
    send_cmd(1, make_msg(e_mem_rd, cfg_addr(k), 1, '0));
    expect_resp(1, make_msg(e_mem_rd, cfg_addr(k), 1, data));
  end
endtask

task automatic loopback_test();
  logic [`PADDR_W-1:0] addr;
  mem_msg_s            msg;
  for (int k = 0; k < 2; k++)
  begin
    addr = (`PADDR_W'(k == 0 ? 3 : 7) << `DEV_LSB) | `PADDR_W'(lcg_next() & 32'hf_ffff);
    msg  = make_msg(mem_op_e'(k), addr, 2'(1 - k), {lcg_next(), lcg_next()});
    send_cmd(1 - k, msg);
    expect_resp(1 - k, make_msg(msg.op, addr, msg.src_id, '0));
  end
endtask

task automatic mem_test();
  logic [63:0] r;
  mem_msg_s    msg;
  for (int k = 0; k < 4; k++)
  begin
    r   = {lcg_next(), lcg_next()};
    msg = make_msg(mem_op_e'(r[63]), `PADDR_W'(r[36:0]) | `DRAM_BASE, 2'(k % 2),
                   {lcg_next(), lcg_next()});
    send_cmd(k % 2, msg);
    expect_routed(1'b0, msg);
    expect_resp(k % 2, mem_reply(msg));
  end
endtask

task automatic io_test();
  logic [63:0]        r;
  logic [`DATA_W-1:0] data;
  mem_msg_s           msg;
  r   = {lcg_next(), lcg_next()};
  msg = make_msg(e_mem_rd, {3'(1 + r[63:61] % 7), r[36:0]}, 1, '0);
  send_cmd(1, msg);
  expect_routed(1'b1, msg);
  expect_resp(1, io_reply(msg));
  if (mem_seen_q.size() != 0)
    report_failure("I/O command also reached memory");
  // Incoming I/O uses the cfg device
  data = {lcg_next(), lcg_next()};
  send_cmd(2, make_msg(e_mem_wr, cfg_addr(2), 2, data));
  expect_resp(2, make_msg(e_mem_wr, cfg_addr(2), 2, '0));
  send_cmd(2, make_msg(e_mem_rd, cfg_addr(2), 2, '0));
  expect_resp(2, make_msg(e_mem_rd, cfg_addr(2), 2, data));
endtask

// Port 1 outranks port 0 once memory becomes ready
task automatic priority_test();
  mem_msg_s m0;
  mem_msg_s m1;
  m0 = make_msg(e_mem_rd, `DRAM_BASE | `PADDR_W'(lcg_next()), 0, '0);
  m1 = make_msg(e_mem_wr, `DRAM_BASE | `PADDR_W'(lcg_next()), 1, {lcg_next(), lcg_next()});
  @(negedge clk_i);
  mem_cmd_ready_i = 1'b0;
  fork
    send_cmd(0, m0);
    send_cmd(1, m1);
  join
  // Both commands stay in their FIFOs while memory is busy
  if (mem_cmd_v_o !== 1'b0)
    report_mismatch("mem_cmd_v_o", mem_cmd_v_o, 1'b0);
  @(negedge clk_i);
  mem_cmd_ready_i = 1'b1;
  expect_routed(1'b0, m1);
  expect_routed(1'b0, m0);
  expect_resp(1, mem_reply(m1));
  expect_resp(0, mem_reply(m0));
endtask

task automatic backpressure_test();
  mem_msg_s exp0_q[$];
  mem_msg_s exp1_q[$];
  mem_msg_s msg;
  mem_msg_s exp;
  int       port;
  int       cycles;
  mem_seen_q.delete();
  @(negedge clk_i);
  proc_resp_ready_i = 2'b00;
  for (int k = 0; k < 4; k++)
  begin
    msg = make_msg(e_mem_rd, `DRAM_BASE | `PADDR_W'(lcg_next()), 2'(k % 2), '0);
    if (k % 2 == 0)
      exp0_q.push_back(mem_reply(msg));
    else
      exp1_q.push_back(mem_reply(msg));
    send_cmd(k % 2, msg);
  end
  // Port 0 fills its response FIFO, so the last reply waits in the memory model
  cycles = 0;
  while ((mem_seen_q.size() != 4 || mem_pend_q.size() != 1) && cycles < TIMEOUT)
  begin
    @(negedge clk_i);
    cycles++;
  end
  if (mem_seen_q.size() != 4 || mem_pend_q.size() != 1)
    report_failure("memory responses did not reach the response FIFOs");
  if (proc_resp_v_o !== 2'b11)
    report_mismatch("proc_resp_v_o", proc_resp_v_o, 2'b11);
  if (proc_resp_o[0] !== exp0_q[0])
    report_mismatch("proc_resp_o[0]", proc_resp_o[0], exp0_q[0]);
  if (proc_resp_o[1] !== exp1_q[0])
    report_mismatch("proc_resp_o[1]", proc_resp_o[1], exp1_q[0]);
  mem_seen_q.delete();
  proc_resp_ready_i = 2'b11;
  for (int k = 0; k < 4; k++)
  begin
    wait_resp(msg, port);
    if (port == 0 && exp0_q.size() != 0)
    begin
      exp = exp0_q.pop_front();
      if (msg !== exp)
        report_mismatch("proc_resp_o[0]", msg, exp);
    end
    else if (port == 1 && exp1_q.size() != 0)
    begin
      exp = exp1_q.pop_front();
      if (msg !== exp)
        report_mismatch("proc_resp_o[1]", msg, exp);
    end
    else if (port >= 0)
      report_failure($sformatf("unexpected extra response on port %0d", port));
  end
  if (exp0_q.size() != 0 || exp1_q.size() != 0)
    report_failure("held responses were lost");
endtask

`endif

//--- test/tb_uncore.sv
`include "uncore_defines.svh"

module tb_uncore
  import uncore_pkg::*;
  ();

  localparam int TIMEOUT = 200;

  logic                clk_i;
  logic                reset_i;

  mem_msg_s [1:0]      proc_cmd_i;
  logic     [1:0]      proc_cmd_v_i;
  logic     [1:0]      proc_cmd_ready_o;
  mem_msg_s [1:0]      proc_resp_o;
  logic     [1:0]      proc_resp_v_o;
  logic     [1:0]      proc_resp_ready_i;

  mem_msg_s            io_cmd_i;
  logic                io_cmd_v_i;
  logic                io_cmd_yumi_o;
  mem_msg_s            io_resp_o;
  logic                io_resp_v_o;
  logic                io_resp_ready_i;

  mem_msg_s            io_cmd_o;
  logic                io_cmd_v_o;
  logic                io_cmd_ready_i;
  mem_msg_s            io_resp_in_i;
  logic                io_resp_in_v_i;
  logic                io_resp_in_yumi_o;

  mem_msg_s            mem_cmd_o;
  logic                mem_cmd_v_o;
  logic                mem_cmd_ready_i;
  mem_msg_s            mem_resp_i;
  logic                mem_resp_v_i;
  logic                mem_resp_yumi_o;

  int                  mismatches = 0;
  int                  failures = 0;
  logic [31:0]         lcg_state = 32'd78341;

  // Responses owed by the memory and I/O models, oldest first
  mem_msg_s            mem_pend_q[$];
  mem_msg_s            io_pend_q[$];
  // Commands seen leaving the DUT
  mem_msg_s            mem_seen_q[$];
  mem_msg_s            io_seen_q[$];
  // Responses taken from the DUT and the port each came out of
  mem_msg_s            got_q[$];
  int                  got_port_q[$];

  unicore_uncore
   dut_i
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.proc_cmd_i(proc_cmd_i)
     ,.proc_cmd_v_i(proc_cmd_v_i)
     ,.proc_cmd_ready_o(proc_cmd_ready_o)
     ,.proc_resp_o(proc_resp_o)
     ,.proc_resp_v_o(proc_resp_v_o)
     ,.proc_resp_ready_i(proc_resp_ready_i)
     ,.io_cmd_i(io_cmd_i)
     ,.io_cmd_v_i(io_cmd_v_i)
     ,.io_cmd_yumi_o(io_cmd_yumi_o)
     ,.io_resp_o(io_resp_o)
     ,.io_resp_v_o(io_resp_v_o)
     ,.io_resp_ready_i(io_resp_ready_i)
     ,.io_cmd_o(io_cmd_o)
     ,.io_cmd_v_o(io_cmd_v_o)
     ,.io_cmd_ready_i(io_cmd_ready_i)
     ,.io_resp_in_i(io_resp_in_i)
     ,.io_resp_in_v_i(io_resp_in_v_i)
     ,.io_resp_in_yumi_o(io_resp_in_yumi_o)
     ,.mem_cmd_o(mem_cmd_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     );

  `include "tb_uncore_tasks.svh"

  initial
  begin
    clk_i = 1'b0;
    forever
      #50 clk_i = ~clk_i;
  end

  // Handshakes complete at the rising edge, so sample there
  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      if (mem_resp_v_i & mem_resp_yumi_o)
        void'(mem_pend_q.pop_front());
      if (io_resp_in_v_i & io_resp_in_yumi_o)
        void'(io_pend_q.pop_front());
      if (mem_cmd_v_o & mem_cmd_ready_i)
      begin
        mem_seen_q.push_back(mem_cmd_o);
        mem_pend_q.push_back(mem_reply(mem_cmd_o));
      end
      if (io_cmd_v_o & io_cmd_ready_i)
      begin
        io_seen_q.push_back(io_cmd_o);
        io_pend_q.push_back(io_reply(io_cmd_o));
      end
      for (int p = 0; p < 2; p++)
      begin
        if (proc_resp_v_o[p] & proc_resp_ready_i[p])
          record_resp(proc_resp_o[p], p);
      end
      if (io_resp_v_o & io_resp_ready_i)
        record_resp(io_resp_o, 2);
    end
  end

  // Memory and I/O responders present their oldest pending reply
  always @(negedge clk_i)
  begin
    mem_resp_v_i = (mem_pend_q.size() != 0);
    if (mem_resp_v_i)
      mem_resp_i = mem_pend_q[0];
    else
      mem_resp_i = '0;
    io_resp_in_v_i = (io_pend_q.size() != 0);
    if (io_resp_in_v_i)
      io_resp_in_i = io_pend_q[0];
    else
      io_resp_in_i = '0;
  end

  initial
  begin
    reset_i           = 1'b1;
    proc_cmd_i        = '0;
    proc_cmd_v_i      = '0;
    proc_resp_ready_i = 2'b11;
    io_cmd_i          = '0;
    io_cmd_v_i        = 1'b0;
    io_resp_ready_i   = 1'b1;
    io_cmd_ready_i    = 1'b1;
    io_resp_in_i      = '0;
    io_resp_in_v_i    = 1'b0;
    mem_cmd_ready_i   = 1'b1;
    mem_resp_i        = '0;
    mem_resp_v_i      = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    cfg_test();
    loopback_test();
    mem_test();
    io_test();
    priority_test();
    backpressure_test();

    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- hdl/unicore_uncore.sv
`include "uncore_defines.svh"

module unicore_uncore
  import uncore_pkg::*;
  (
      input  logic                    clk_i
    , input  logic                    reset_i

    // Processor side, 0 is instruction and 1 is data
    , input  mem_msg_s [`NUM_REQ-2:0] proc_cmd_i
    , input  logic     [`NUM_REQ-2:0] proc_cmd_v_i
    , output logic     [`NUM_REQ-2:0] proc_cmd_ready_o

    , output mem_msg_s [`NUM_REQ-2:0] proc_resp_o
    , output logic     [`NUM_REQ-2:0] proc_resp_v_o
    , input  logic     [`NUM_REQ-2:0] proc_resp_ready_i

    // Incoming I/O
    , input  mem_msg_s                io_cmd_i
    , input  logic                    io_cmd_v_i
    , output logic                    io_cmd_yumi_o

    , output mem_msg_s                io_resp_o
    , output logic                    io_resp_v_o
    , input  logic                    io_resp_ready_i

    // Outgoing I/O
    , output mem_msg_s                io_cmd_o
    , output logic                    io_cmd_v_o
    , input  logic                    io_cmd_ready_i

    , input  mem_msg_s                io_resp_in_i
    , input  logic                    io_resp_in_v_i
    , output logic                    io_resp_in_yumi_o

    // Memory
    , output mem_msg_s                mem_cmd_o
    , output logic                    mem_cmd_v_o
    , input  logic                    mem_cmd_ready_i

    , input  mem_msg_s                mem_resp_i
    , input  logic                    mem_resp_v_i
    , output logic                    mem_resp_yumi_o
  );

  localparam int MSG_W = $bits(mem_msg_s);

  mem_msg_s [`NUM_REQ-1:0] req_cmd;
  logic     [`NUM_REQ-1:0] req_cmd_v;
  logic     [`NUM_REQ-1:0] req_cmd_ready;
  mem_msg_s [`NUM_REQ-1:0] req_resp;
  logic     [`NUM_REQ-1:0] req_resp_v;
  logic     [`NUM_REQ-1:0] req_resp_yumi;

  mem_msg_s [`NUM_REQ-1:0] cmd_fifo_lo;
  logic     [`NUM_REQ-1:0] cmd_fifo_v_lo;
  logic     [`NUM_REQ-1:0] cmd_fifo_yumi_li;
  mem_msg_s                resp_fifo_li;
  logic     [`NUM_REQ-1:0] resp_fifo_v_li;
  logic     [`NUM_REQ-1:0] resp_fifo_ready_lo;

  mem_msg_s routed_cmd;
  logic     cfg_cmd_v, cfg_cmd_ready;
  logic     loop_cmd_v, loop_cmd_ready;
  mem_msg_s cfg_resp, loop_resp;
  logic     cfg_resp_v, cfg_resp_yumi;
  logic     loop_resp_v, loop_resp_yumi;

  // Incoming I/O acts as the third requester
  assign req_cmd[`NUM_REQ-2:0]  = proc_cmd_i;
  assign req_cmd[`NUM_REQ-1]    = io_cmd_i;
  assign req_cmd_v              = {io_cmd_v_i, proc_cmd_v_i};
  assign proc_cmd_ready_o       = req_cmd_ready[`NUM_REQ-2:0];
  assign io_cmd_yumi_o          = req_cmd_ready[`NUM_REQ-1] & io_cmd_v_i;

  assign proc_resp_o   = req_resp[`NUM_REQ-2:0];
  assign proc_resp_v_o = req_resp_v[`NUM_REQ-2:0];
  assign io_resp_o     = req_resp[`NUM_REQ-1];
  assign io_resp_v_o   = req_resp_v[`NUM_REQ-1];
  assign req_resp_yumi = {io_resp_ready_i, proc_resp_ready_i} & req_resp_v;

  // No L2, so memory and outgoing I/O see the routed command as is
  assign io_cmd_o  = routed_cmd;
  assign mem_cmd_o = routed_cmd;

  for (genvar i = 0; i < `NUM_REQ; i++)
  begin : fifo
    two_fifo
     #(.width_p(MSG_W))
     cmd_fifo
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.data_i(req_cmd[i])
       ,.v_i(req_cmd_v[i])
       ,.ready_o(req_cmd_ready[i])
       ,.data_o(cmd_fifo_lo[i])
       ,.v_o(cmd_fifo_v_lo[i])
       ,.yumi_i(cmd_fifo_yumi_li[i])
       );

    two_fifo
     #(.width_p(MSG_W))
     resp_fifo
      (.clk_i(clk_i)
       ,.reset_i(reset_i)
       ,.data_i(resp_fifo_li)
       ,.v_i(resp_fifo_v_li[i])
       ,.ready_o(resp_fifo_ready_lo[i])
       ,.data_o(req_resp[i])
       ,.v_o(req_resp_v[i])
       ,.yumi_i(req_resp_yumi[i])
       );
  end

  cmd_router
   cmd_rtr
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.fifo_cmd_i(cmd_fifo_lo)
     ,.fifo_v_i(cmd_fifo_v_lo)
     ,.fifo_yumi_o(cmd_fifo_yumi_li)
     ,.cfg_ready_i(cfg_cmd_ready)
     ,.loop_ready_i(loop_cmd_ready)
     ,.io_ready_i(io_cmd_ready_i)
     ,.mem_ready_i(mem_cmd_ready_i)
     ,.cmd_o(routed_cmd)
     ,.cfg_v_o(cfg_cmd_v)
     ,.loop_v_o(loop_cmd_v)
     ,.io_v_o(io_cmd_v_o)
     ,.mem_v_o(mem_cmd_v_o)
     );

  resp_router
   resp_rtr
    (.loop_resp_i(loop_resp)
     ,.loop_resp_v_i(loop_resp_v)
     ,.loop_resp_yumi_o(loop_resp_yumi)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     ,.io_resp_i(io_resp_in_i)
     ,.io_resp_v_i(io_resp_in_v_i)
     ,.io_resp_yumi_o(io_resp_in_yumi_o)
     ,.cfg_resp_i(cfg_resp)
     ,.cfg_resp_v_i(cfg_resp_v)
     ,.cfg_resp_yumi_o(cfg_resp_yumi)
     ,.fifo_ready_i(resp_fifo_ready_lo)
     ,.resp_o(resp_fifo_li)
     ,.resp_v_o(resp_fifo_v_li)
     );

  cfg_regs
   cfg_dev
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_i(routed_cmd)
     ,.cmd_v_i(cfg_cmd_v)
     ,.cmd_ready_o(cfg_cmd_ready)
     ,.resp_o(cfg_resp)
     ,.resp_v_o(cfg_resp_v)
     ,.resp_yumi_i(cfg_resp_yumi)
     );

  loopback
   loop_dev
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_i(routed_cmd)
     ,.cmd_v_i(loop_cmd_v)
     ,.cmd_ready_o(loop_cmd_ready)
     ,.resp_o(loop_resp)
     ,.resp_v_o(loop_resp_v)
     ,.resp_yumi_i(loop_resp_yumi)
     );

endmodule

//--- hdl/loopback.sv
module loopback
  import uncore_pkg::*;
  (
      input  logic     clk_i
    , input  logic     reset_i

    , input  mem_msg_s cmd_i
    , input  logic     cmd_v_i
    , output logic     cmd_ready_o

    , output mem_msg_s resp_o
    , output logic     resp_v_o
    , input  logic     resp_yumi_i
  );

  mem_msg_s resp_r;
  logic     resp_v_r;
  logic     accept;

  // One response in flight at a time
  assign accept = cmd_v_i & ~resp_v_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_r      <= cmd_i;
      resp_r.data <= '0;
    end
  end

  assign cmd_ready_o = ~resp_v_r;
  assign resp_o      = resp_r;
  assign resp_v_o    = resp_v_r;

endmodule

//--- hdl/cfg_regs.sv
`include "uncore_defines.svh"

module cfg_regs
  import uncore_pkg::*;
  (
      input  logic     clk_i
    , input  logic     reset_i

    , input  mem_msg_s cmd_i
    , input  logic     cmd_v_i
    , output logic     cmd_ready_o

    , output mem_msg_s resp_o
    , output logic     resp_v_o
    , input  logic     resp_yumi_i
  );

  localparam int IDX_W = $clog2(`CFG_REGS);

  logic [`DATA_W-1:0] regs_r [`CFG_REGS];
  logic [IDX_W-1:0]   idx;
  logic               accept;
  logic               is_wr;
  mem_msg_s           resp_r;
  logic               resp_v_r;

  // Registers sit on 8-byte boundaries
  assign idx    = cmd_i.addr.fld.offset[3+:IDX_W];
  assign is_wr  = (cmd_i.op == e_mem_wr);
  assign accept = cmd_v_i & ~resp_v_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int i = 0; i < `CFG_REGS; i++)
        regs_r[i] <= '0;
    end
    else if (accept & is_wr)
      regs_r[idx] <= cmd_i.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  // Header echoes the command, writes return zero data
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_r      <= cmd_i;
      resp_r.data <= is_wr ? '0 : regs_r[idx];
    end
  end

  assign cmd_ready_o = ~resp_v_r;
  assign resp_o      = resp_r;
  assign resp_v_o    = resp_v_r;

endmodule

//--- hdl/resp_router.sv
`include "uncore_defines.svh"

module resp_router
  import uncore_pkg::*;
  (
      input  mem_msg_s            loop_resp_i
    , input  logic                loop_resp_v_i
    , output logic                loop_resp_yumi_o

    , input  mem_msg_s            mem_resp_i
    , input  logic                mem_resp_v_i
    , output logic                mem_resp_yumi_o

    , input  mem_msg_s            io_resp_i
    , input  logic                io_resp_v_i
    , output logic                io_resp_yumi_o

    , input  mem_msg_s            cfg_resp_i
    , input  logic                cfg_resp_v_i
    , output logic                cfg_resp_yumi_o

    , input  logic [`NUM_REQ-1:0] fifo_ready_i
    , output mem_msg_s            resp_o
    , output logic [`NUM_REQ-1:0] resp_v_o
  );

  localparam int NUM_SRC = 4;
  localparam int MSG_W   = $bits(mem_msg_s);

  mem_msg_s [NUM_SRC-1:0] src_resp;
  logic     [NUM_SRC-1:0] src_v;
  logic     [NUM_SRC-1:0] grant;
  logic     [MSG_W-1:0]   sel_bits;
  logic                   granted;

  // Index 0 is loopback and has the highest priority
  assign src_resp = {cfg_resp_i, io_resp_i, mem_resp_i, loop_resp_i};
  assign src_v    = {cfg_resp_v_i, io_resp_v_i, mem_resp_v_i, loop_resp_v_i};

  // Wait until every response FIFO has room
  always_comb
  begin
    grant = '0;
    if (&fifo_ready_i)
    begin
      for (int i = NUM_SRC-1; i >= 0; i--)
      begin
        if (src_v[i])
        begin
          grant    = '0;
          grant[i] = 1'b1;
        end
      end
    end
  end

  assign {cfg_resp_yumi_o, io_resp_yumi_o, mem_resp_yumi_o, loop_resp_yumi_o} = grant;

  always_comb
  begin
    sel_bits = '0;
    for (int i = 0; i < NUM_SRC; i++)
      sel_bits = sel_bits | ({MSG_W{grant[i]}} & src_resp[i]);
  end

  assign granted = |grant;
  assign resp_o  = mem_msg_s'(sel_bits);

  // Steer back to the requester named in the message
  always_comb
  begin
    for (int i = 0; i < `NUM_REQ; i++)
      resp_v_o[i] = granted & (resp_o.src_id == i);
  end

endmodule

//--- hdl/cmd_router.sv
`include "uncore_defines.svh"

module cmd_router
  import uncore_pkg::*;
  (
      input  logic                    clk_i
    , input  logic                    reset_i

    , input  mem_msg_s [`NUM_REQ-1:0] fifo_cmd_i
    , input  logic     [`NUM_REQ-1:0] fifo_v_i
    , output logic     [`NUM_REQ-1:0] fifo_yumi_o

    , input  logic                    cfg_ready_i
    , input  logic                    loop_ready_i
    , input  logic                    io_ready_i
    , input  logic                    mem_ready_i

    , output mem_msg_s                cmd_o
    , output logic                    cfg_v_o
    , output logic                    loop_v_o
    , output logic                    io_v_o
    , output logic                    mem_v_o
  );

  localparam int MSG_W = $bits(mem_msg_s);

  logic                arb_en_r;
  logic                dest_ready;
  logic [`NUM_REQ-1:0] grant;
  logic                granted;
  logic [MSG_W-1:0]    sel_bits;
  paddr_u              addr;
  logic [`DEV_W-1:0]   dev;
  logic                is_local;
  logic                is_other_domain;
  logic                is_io;
  logic                is_cfg;
  logic                is_mem;
  logic                is_loop;

  // Grants open the cycle after reset releases
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      arb_en_r <= 1'b0;
    else
      arb_en_r <= 1'b1;
  end

  // Any busy destination stalls every requester
  assign dest_ready = cfg_ready_i & loop_ready_i & io_ready_i & mem_ready_i;

  // Fixed priority, highest port index wins
  always_comb
  begin
    grant = '0;
    if (arb_en_r & dest_ready)
    begin
      for (int i = 0; i < `NUM_REQ; i++)
      begin
        if (fifo_v_i[i])
        begin
          grant    = '0;
          grant[i] = 1'b1;
        end
      end
    end
  end

  always_comb
  begin
    sel_bits = '0;
    for (int i = 0; i < `NUM_REQ; i++)
      sel_bits = sel_bits | ({MSG_W{grant[i]}} & fifo_cmd_i[i]);
  end

  assign granted     = |grant;
  assign fifo_yumi_o = grant;
  assign cmd_o       = mem_msg_s'(sel_bits);

  assign addr = cmd_o.addr;
  assign dev  = addr.fld.dev;

  assign is_local        = (addr.raw < `DRAM_BASE);
  assign is_other_domain = |addr.fld.did;

  // I/O takes precedence over memory for other-domain addresses
  assign is_io   = is_other_domain
                 | (is_local & ((dev == `BOOT_DEV) | (dev == `HOST_DEV)));
  assign is_cfg  = ~is_io & is_local & (dev == `CFG_DEV);
  assign is_mem  = ~is_io & ~is_cfg & (~is_local | (dev == `CACHE_DEV));
  assign is_loop = ~is_io & ~is_cfg & ~is_mem;

  assign io_v_o   = granted & is_io;
  assign cfg_v_o  = granted & is_cfg;
  assign mem_v_o  = granted & is_mem;
  assign loop_v_o = granted & is_loop;

endmodule

//--- hdl/two_fifo.sv
module two_fifo
  #(parameter int width_p = 8)
  (
      input  logic               clk_i
    , input  logic               reset_i

    , input  logic [width_p-1:0] data_i
    , input  logic               v_i
    , output logic               ready_o

    , output logic [width_p-1:0] data_o
    , output logic               v_o
    , input  logic               yumi_i
  );

  logic [width_p-1:0] mem_r [2];
  logic               wptr_r;
  logic               rptr_r;
  logic               full_r;
  logic               empty_r;
  logic               enq;
  logic               deq;

  assign enq = v_i & ~full_r;
  assign deq = yumi_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end
    else
    begin
      if (enq)
        wptr_r <= ~wptr_r;
      if (deq)
        rptr_r <= ~rptr_r;
      // Occupancy only changes when exactly one side moves
      if (enq & ~deq)
      begin
        empty_r <= 1'b0;
        full_r  <= (~wptr_r == rptr_r);
      end
      else if (deq & ~enq)
      begin
        full_r  <= 1'b0;
        empty_r <= (~rptr_r == wptr_r);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wptr_r] <= data_i;
  end

  assign data_o  = mem_r[rptr_r];
  assign v_o     = ~empty_r;
  assign ready_o = ~full_r;

endmodule

//--- hdl/uncore_pkg.sv
`include "uncore_defines.svh"

package uncore_pkg;

  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  // Address as the memory map slices it
  typedef struct packed
  {
    logic [`DID_W-1:0]                           did;
    logic [`PADDR_W-`DID_W-`DEV_W-`DEV_LSB-1:0] unused;
    logic [`DEV_W-1:0]                           dev;
    logic [`DEV_LSB-1:0]                         offset;
  } paddr_fields_s;

  // Raw view for range compares, field view for device decode
  typedef union packed
  {
    logic [`PADDR_W-1:0] raw;
    paddr_fields_s       fld;
  } paddr_u;

  // One command or response
  typedef struct packed
  {
    mem_op_e              op;
    paddr_u               addr;
    logic [`SRC_ID_W-1:0] src_id;
    logic [`DATA_W-1:0]   data;
  } mem_msg_s;

endpackage

//--- hdl/uncore_defines.svh
`ifndef UNCORE_DEFINES_SVH
`define UNCORE_DEFINES_SVH

// Message field widths
`define PADDR_W   40
`define DATA_W    64
`define SRC_ID_W  2

// Requester ports, port 2 is incoming I/O
`define NUM_REQ   3

// Address map layout
`define DID_W     3
`define DEV_LSB   20
`define DEV_W     4
`define DRAM_BASE 40'h00_8000_0000

// Local device numbers
`define BOOT_DEV  4'd0
`define HOST_DEV  4'd1
`define CFG_DEV   4'd2
`define CACHE_DEV 4'd4

`define CFG_REGS  4

`endif
